//--- Bender.yml
package:
  name: whitening

sources:
  - files:
      - logic/whiteningPkg.sv
      - logic/whiteningController.sv
      - logic/sampleMemory.sv
      - logic/centeringUnit.sv
      - logic/covarianceAccumulator.sv
      - logic/whiteningMultiplier.sv
      - logic/whiteningTop.sv
  - target: test
    files:
      - dv/clockGen.sv
      - dv/whiteningChecker.sv
      - dv/whiteningTb.sv

//--- dv/clockGen.sv
`timescale 1ns/1ns

module clockGen #(
	parameter int Period = 8,
	parameter int ResetCycles = 2
) (
	output logic CLK_Whitening,
	output logic GO_whitening
);

	initial begin
		CLK_Whitening = 1'b0;
		forever #(Period / 2) CLK_Whitening = ~CLK_Whitening;
	end

	initial begin
		GO_whitening = 1'b0;
		repeat (ResetCycles) @(posedge CLK_Whitening);
		@(negedge CLK_Whitening); // release away from the active edge
		GO_whitening = 1'b1;
	end

endmodule

//--- dv/whiteningChecker.sv
`timescale 1ns/1ns

module whiteningChecker #(
	parameter int AddrBits = 7,
	parameter int OutCredits = 4
) (
	input  logic                 CLK_Whitening,
	input  logic                 GO_whitening,
	input  logic                 start,
	input  logic                 busy,
	input  logic                 done,
	input  logic                 inValid,
	input  whiteningPkg::sampleT inSample,
	input  logic                 inCredit,
	input  logic                 covValid,
	input  whiteningPkg::covT    covOut,
	input  logic                 matValid,
	input  whiteningPkg::matrixT matIn,
	input  logic                 outValid,
	input  whiteningPkg::sampleT outSample,
	input  logic                 outCredit,
	output int                   checks,
	output int                   covErrors,
	output int                   dataErrors,
	output int                   flowErrors
);

	import whiteningPkg::*;

	localparam int NumSamples = 2**AddrBits;

	sampleT blk [NumSamples]; // raw samples of the current block
	sampleT meanRef;
	covT    expCov;
	sampleT expOut;
	matrixT mat;
	int     blockNo;
	int     inCount;
	int     outCount;
	int     creditCount;
	int     unanswered; // outputs not yet paid back by outCredit
	logic   lastAccept;
	logic   covSeen;
	logic   doneSeen;

	function automatic sampleT meanOf();
		longint sum0;
		longint sum1;
		sampleT m;
		sum0 = 0;
		sum1 = 0;
		for (int i = 0; i < NumSamples; i++) begin
			sum0 += blk[i].ch0;
			sum1 += blk[i].ch1;
		end
		m.ch0 = 16'(sum0 >>> AddrBits); // floor
		m.ch1 = 16'(sum1 >>> AddrBits);
		return m;
	endfunction

	function automatic covT covOf(sampleT m);
		longint c0;
		longint c1;
		longint s00;
		longint s01;
		longint s11;
		covT c;
		s00 = 0;
		s01 = 0;
		s11 = 0;
		for (int i = 0; i < NumSamples; i++) begin
			c0 = longint'(blk[i].ch0) - m.ch0;
			c1 = longint'(blk[i].ch1) - m.ch1;
			s00 += c0 * c0;
			s01 += c0 * c1;
			s11 += c1 * c1;
		end
		c.c00 = 48'(s00 >>> AddrBits);
		c.c01 = 48'(s01 >>> AddrBits);
		c.c11 = 48'(s11 >>> AddrBits);
		return c;
	endfunction

	function automatic logic signed [15:0] clip16(longint v);
		if (v > 32767) return 16'sh7fff;
		else if (v < -32768) return 16'sh8000;
		else return v[15:0];
	endfunction

	function automatic sampleT whitenOf(sampleT raw, sampleT m, matrixT w);
		longint c0;
		longint c1;
		longint half;
		sampleT r;
		c0 = longint'(raw.ch0) - m.ch0;
		c1 = longint'(raw.ch1) - m.ch1;
		half = longint'(1) <<< (MatFrac - 1);
		r.ch0 = clip16((w.w00 * c0 + w.w01 * c1 + half) >>> MatFrac);
		r.ch1 = clip16((w.w10 * c0 + w.w11 * c1 + half) >>> MatFrac);
		return r;
	endfunction

	initial begin
		checks = 0;
		covErrors = 0;
		dataErrors = 0;
		flowErrors = 0;
		blockNo = 0;
		unanswered = 0;
		lastAccept = 1'b0;
	end

	always @(posedge CLK_Whitening) begin
		if (GO_whitening) begin
			if (start) begin
				blockNo++;
				inCount = 0;
				outCount = 0;
				creditCount = 0;
				covSeen = 1'b0;
				doneSeen = 1'b0;
			end
			if (inCredit !== lastAccept) begin
				flowErrors++;
				$display("inCredit in block %0d did not follow an accepted sample by one cycle",
					blockNo);
			end
			lastAccept = inValid && busy;
			if (inCredit) creditCount++;
			if (inValid) begin
				blk[inCount] = inSample;
				inCount++;
			end
			if (covValid) begin
				meanRef = meanOf();
				expCov = covOf(meanRef);
				covSeen = 1'b1;
				checks++;
				if (covOut !== expCov) begin
					covErrors++;
					$display("FAILED cov block%0d: expected %0d %0d %0d, actual %0d %0d %0d",
						blockNo, expCov.c00, expCov.c01, expCov.c11,
						covOut.c00, covOut.c01, covOut.c11);
				end
			end
			if (matValid) mat = matIn;
			if (outValid) begin
				if (outCount >= NumSamples) begin
					flowErrors++;
					$display("block %0d produced more than %0d outputs", blockNo, NumSamples);
				end else begin
					expOut = whitenOf(blk[outCount], meanRef, mat);
					checks++;
					if (outSample !== expOut) begin
						dataErrors++;
						$display("FAILED out block%0d sample%0d: expected %0d %0d, actual %0d %0d",
							blockNo, outCount, expOut.ch0, expOut.ch1,
							outSample.ch0, outSample.ch1);
					end
				end
				outCount++;
			end
			unanswered += int'(outValid) - int'(outCredit);
			if (unanswered > OutCredits) begin
				flowErrors++;
				$display("%0d outputs held against %0d output credits", unanswered, OutCredits);
			end
			if (done) begin
				checks++;
				if (doneSeen) begin
					flowErrors++;
					$display("second done pulse in block %0d", blockNo);
				end
				doneSeen = 1'b1;
				if (outCount != NumSamples) begin
					flowErrors++;
					$display("FAILED outcount block%0d: expected %0d, actual %0d",
						blockNo, NumSamples, outCount);
				end
				if (creditCount != NumSamples) begin
					flowErrors++;
					$display("FAILED incredit block%0d: expected %0d, actual %0d",
						blockNo, NumSamples, creditCount);
				end
				if (busy) begin
					flowErrors++;
					$display("busy still high at done in block %0d", blockNo);
				end
				if (!covSeen) begin
					flowErrors++;
					$display("block %0d finished without a covariance result", blockNo);
				end
			end
		end
	end

endmodule

//--- dv/whiteningTb.sv
`timescale 1ns/1ns

module whiteningTb;

	import whiteningPkg::*;

	localparam int AddrBits = 7;
	localparam int OutCredits = 4;
	localparam int NumSamples = 2**AddrBits;
	localparam int Blocks = 3;
	localparam int TimeoutNs = Blocks * (NumSamples * 8 + 200) * 8;

	logic   CLK_Whitening;
	logic   GO_whitening;
	logic   start;
	logic   busy;
	logic   done;
	logic   inValid;
	sampleT inSample;
	logic   inCredit;
	logic   covValid;
	covT    covOut;
	logic   matValid;
	matrixT matIn;
	logic   outValid;
	sampleT outSample;
	logic   outCredit;
	int     checks;
	int     covErrors;
	int     dataErrors;
	int     flowErrors;
	integer seed;
	int     blockKind = 0;
	int     creditsBack = 0; // inCredit pulses seen this block
	int     owed = 0; // output credits still to hand back

	clockGen clk0 (
		.CLK_Whitening(CLK_Whitening),
		.GO_whitening(GO_whitening)
	);

	whiteningTop #(
		.AddrBits(AddrBits),
		.OutCredits(OutCredits)
	) dut0 (
		.CLK_Whitening(CLK_Whitening),
		.GO_whitening(GO_whitening),
		.start(start),
		.busy(busy),
		.done(done),
		.inValid(inValid),
		.inSample(inSample),
		.inCredit(inCredit),
		.covValid(covValid),
		.covOut(covOut),
		.matValid(matValid),
		.matIn(matIn),
		.outValid(outValid),
		.outSample(outSample),
		.outCredit(outCredit)
	);

	whiteningChecker #(
		.AddrBits(AddrBits),
		.OutCredits(OutCredits)
	) chk0 (
		.CLK_Whitening(CLK_Whitening),
		.GO_whitening(GO_whitening),
		.start(start),
		.busy(busy),
		.done(done),
		.inValid(inValid),
		.inSample(inSample),
		.inCredit(inCredit),
		.covValid(covValid),
		.covOut(covOut),
		.matValid(matValid),
		.matIn(matIn),
		.outValid(outValid),
		.outSample(outSample),
		.outCredit(outCredit),
		.checks(checks),
		.covErrors(covErrors),
		.dataErrors(dataErrors),
		.flowErrors(flowErrors)
	);

	function automatic sampleT makeSample(int kind);
		sampleT s;
		if (kind == 0) begin
			s.ch0 = 16'(1000 + $random(seed) % 2048);
			s.ch1 = 16'(-3000 + $random(seed) % 2048);
		end else if (kind == 1) begin
			s.ch0 = 16'(-7000 + $random(seed) % 8000);
			s.ch1 = 16'(5000 + $random(seed) % 8000);
		end else begin
			s.ch0 = ($random(seed) & 1) ? 16'sh7fff : 16'sh8000; // full scale
			s.ch1 = ($random(seed) & 1) ? 16'sh7fff : 16'sh8000;
		end
		return s;
	endfunction

	function automatic matrixT makeMatrix(int kind);
		matrixT w;
		if (kind < 2) begin
			w.w00 = 16'($random(seed) % 12000);
			w.w01 = 16'($random(seed) % 12000);
			w.w10 = 16'($random(seed) % 12000);
			w.w11 = 16'($random(seed) % 12000);
		end else begin
			w.w00 = ($random(seed) & 1) ? 16'sh7fff : 16'sh8000; // near +-2.0
			w.w01 = ($random(seed) & 1) ? 16'sh7fff : 16'sh8000;
			w.w10 = ($random(seed) & 1) ? 16'sh7fff : 16'sh8000;
			w.w11 = ($random(seed) & 1) ? 16'sh7fff : 16'sh8000;
		end
		return w;
	endfunction

	task automatic runBlock(input int kind);
		int sent;
		sent = 0;
		blockKind = kind;
		creditsBack = 0;
		@(negedge CLK_Whitening);
		start = 1'b1;
		@(negedge CLK_Whitening);
		start = 1'b0;
		while (sent < NumSamples) begin
			@(negedge CLK_Whitening);
			if (($random(seed) & 3) != 0) begin
				inValid = 1'b1;
				inSample = makeSample(kind);
				sent++;
			end else begin
				inValid = 1'b0;
			end
		end
		@(negedge CLK_Whitening);
		inValid = 1'b0;
		while (!done) @(negedge CLK_Whitening);
		while (creditsBack < NumSamples) @(negedge CLK_Whitening);
	endtask

	always @(negedge CLK_Whitening) begin
		if (inCredit) creditsBack++;
	end

	// solver stand-in
	always begin
		@(negedge CLK_Whitening);
		if (covValid) begin
			repeat ($unsigned($random(seed)) % 16) @(negedge CLK_Whitening);
			@(negedge CLK_Whitening);
			matIn = makeMatrix(blockKind);
			matValid = 1'b1;
			@(negedge CLK_Whitening);
			matValid = 1'b0;
		end
	end

	always @(negedge CLK_Whitening) begin
		if (outValid) owed++;
		if (owed > 0 && ($random(seed) & 1)) begin
			outCredit = 1'b1;
			owed--;
		end else begin
			outCredit = 1'b0;
		end
	end

	initial begin
		#(TimeoutNs);
		$display("timeout after %0d ns, the DUT never finished all blocks", TimeoutNs);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		seed = 32'h72e0_35cd;
		start = 1'b0;
		inValid = 1'b0;
		inSample = '0;
		matValid = 1'b0;
		matIn = '0;
		outCredit = 1'b0;
		@(posedge GO_whitening);
		for (int b = 0; b < Blocks; b++) runBlock(b); // last one saturates
		repeat (4) @(negedge CLK_Whitening);
		$display("checks %0d, cov errors %0d, data errors %0d, flow errors %0d",
			checks, covErrors, dataErrors, flowErrors);
		if (checks > 0 && covErrors + dataErrors + flowErrors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- logic/centeringUnit.sv
`timescale 1ns/1ns

module centeringUnit #(
	parameter int AddrBits = 7
) (
	input  logic                   CLK_Whitening,
	input  logic                   GO_whitening,
	input  logic                   accEn,
	input  logic                   meanLoad,
	input  logic                   start,
	input  whiteningPkg::sampleT   inSample,
	input  whiteningPkg::sampleT   rdData,
	output whiteningPkg::centeredT centered
);

	localparam int SumBits = 16 + AddrBits; // 23 bits at the default size

	logic signed [SumBits-1:0] sumCh0;
	logic signed [SumBits-1:0] sumCh1;
	logic signed [SumBits-1:0] meanFull0;
	logic signed [SumBits-1:0] meanFull1;
	logic signed [15:0]        meanCh0;
	logic signed [15:0]        meanCh1;

	assign meanFull0 = sumCh0 >>> AddrBits; // floor divide by block size
	assign meanFull1 = sumCh1 >>> AddrBits;

	always_ff @(posedge CLK_Whitening or negedge GO_whitening) begin
		if (!GO_whitening) begin
			sumCh0  <= '0;
			sumCh1  <= '0;
			meanCh0 <= '0;
			meanCh1 <= '0;
		end else begin
			if (start) begin
				sumCh0 <= '0;
				sumCh1 <= '0;
			end else if (accEn) begin
				sumCh0 <= sumCh0 + inSample.ch0;
				sumCh1 <= sumCh1 + inSample.ch1;
			end
			if (meanLoad) begin
				meanCh0 <= meanFull0[15:0]; // always fits in 16 bits
				meanCh1 <= meanFull1[15:0];
			end
		end
	end

	always_comb begin
		centered.ch0 = rdData.ch0 - meanCh0;
		centered.ch1 = rdData.ch1 - meanCh1;
	end

endmodule

//--- logic/covarianceAccumulator.sv
`timescale 1ns/1ns

module covarianceAccumulator #(
	parameter int AddrBits = 7
) (
	input  logic                   CLK_Whitening,
	input  logic                   GO_whitening,
	input  logic                   covClear,
	input  logic                   covEn,
	input  whiteningPkg::centeredT centered,
	input  logic                   covDone,
	output logic                   covValid,
	output whiteningPkg::covT      covOut
);

	logic signed [33:0] prod00;
	logic signed [33:0] prod01;
	logic signed [33:0] prod11;
	logic signed [47:0] acc00;
	logic signed [47:0] acc01;
	logic signed [47:0] acc11;
	logic signed [47:0] next00;
	logic signed [47:0] next01;
	logic signed [47:0] next11;

	always_comb begin
		prod00 = centered.ch0 * centered.ch0;
		prod01 = centered.ch0 * centered.ch1;
		prod11 = centered.ch1 * centered.ch1;
		next00 = covEn ? acc00 + prod00 : acc00;
		next01 = covEn ? acc01 + prod01 : acc01;
		next11 = covEn ? acc11 + prod11 : acc11;
	end

	always_ff @(posedge CLK_Whitening) begin
		if (covClear) begin
			acc00 <= '0;
			acc01 <= '0;
			acc11 <= '0;
		end else if (covEn) begin
			acc00 <= next00;
			acc01 <= next01;
			acc11 <= next11;
		end
		// last product still in flight during drain, so scale the next sums
		if (covDone) begin
			covOut.c00 <= next00 >>> AddrBits;
			covOut.c01 <= next01 >>> AddrBits;
			covOut.c11 <= next11 >>> AddrBits;
		end
	end

	always_ff @(posedge CLK_Whitening or negedge GO_whitening) begin
		if (!GO_whitening) covValid <= 1'b0;
		else covValid <= covDone; // single cycle
	end

endmodule

//--- logic/sampleMemory.sv
`timescale 1ns/1ns

module sampleMemory #(
	parameter int AddrBits = 7
) (
	input  logic                  CLK_Whitening,
	input  logic                  wrEn,
	input  logic                  rdEn,
	input  logic [AddrBits-1:0]   addr,
	input  whiteningPkg::sampleT  wrData,
	output whiteningPkg::sampleT  rdData
);

	import whiteningPkg::*;

	sampleT mem [2**AddrBits];

	always_ff @(posedge CLK_Whitening) begin
		if (wrEn) mem[addr] <= wrData;
		if (rdEn) rdData <= mem[addr]; // registered read
	end

	// one port, so load and both read passes never overlap
	portExclusive: assert property (@(posedge CLK_Whitening) !(wrEn && rdEn));

endmodule

//--- logic/whiteningController.sv
`timescale 1ns/1ns

module whiteningController #(
	parameter int AddrBits = 7,
	parameter int OutCredits = 4
) (
	input  logic                CLK_Whitening,
	input  logic                GO_whitening,
	input  logic                start,
	input  logic                inValid,
	input  logic                matValid,
	input  logic                outCredit,
	output logic                busy,
	output logic                done,
	output logic                inCredit,
	output logic                wrEn,
	output logic                rdEn,
	output logic [AddrBits-1:0] addr,
	output logic                accEn,
	output logic                meanLoad,
	output logic                covClear,
	output logic                covEn,
	output logic                covDone,
	output logic                matLoad,
	output logic                applyEn,
	output logic                outValid
);

	import whiteningPkg::*;

	localparam int CredBits = $clog2(OutCredits + 1);

	phaseT               phase;
	logic [AddrBits-1:0] count;
	logic [CredBits-1:0] credits;
	logic [2:0]          pending; // apply reads issued 1, 2 and 3 cycles ago
	logic                covRead;
	logic [1:0]          inFlight;
	logic                lastAddr;
	logic                applyRead;
	logic                lastOut;

	assign lastAddr  = &count;
	assign inFlight  = 2'(pending[0]) + 2'(pending[1]) + 2'(pending[2]);
	assign applyRead = (phase == apply) && (credits > inFlight); // credit left after in-flight reads
	assign lastOut   = (phase == finish) && pending[2] && (pending[1:0] == 2'b00);

	assign busy     = (phase != idle);
	assign wrEn     = (phase == load) && inValid;
	assign rdEn     = (phase == cov) || applyRead;
	assign addr     = count;
	assign accEn    = wrEn;
	assign meanLoad = (phase == mean);
	assign covClear = (phase == mean); // fresh sums before the cov pass
	assign covEn    = covRead;
	assign covDone  = (phase == drain);
	assign matLoad  = (phase == await) && matValid;
	assign applyEn  = (phase == apply) || (phase == finish);
	assign outValid = pending[2];

	always_ff @(posedge CLK_Whitening or negedge GO_whitening) begin
		if (!GO_whitening) begin
			phase <= idle;
			count <= '0;
		end else begin
			case (phase)
				idle: begin
					count <= '0;
					if (start) phase <= load;
				end
				load: begin
					if (wrEn) begin
						count <= count + 1'b1;
						if (lastAddr) phase <= mean;
					end
				end
				mean: phase <= cov;
				cov: begin
					count <= count + 1'b1;
					if (lastAddr) phase <= drain;
				end
				drain: phase <= await;
				await: begin
					if (matValid) phase <= apply;
				end
				apply: begin
					if (applyRead) begin
						count <= count + 1'b1;
						if (lastAddr) phase <= finish;
					end
				end
				finish: begin
					if (lastOut) phase <= idle; // pipeline empty
				end
				default: phase <= idle;
			endcase
		end
	end

	always_ff @(posedge CLK_Whitening or negedge GO_whitening) begin
		if (!GO_whitening) begin
			pending  <= '0;
			covRead  <= 1'b0;
			inCredit <= 1'b0;
			done     <= 1'b0;
			credits  <= CredBits'(OutCredits);
		end else begin
			pending  <= {pending[1:0], applyRead};
			covRead  <= (phase == cov); // rdData valid next cycle
			inCredit <= wrEn;
			done     <= lastOut;
			case ({outValid, outCredit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// source must hold inValid low outside the load phase
	inValidInLoad: assert property (@(posedge CLK_Whitening) disable iff (!GO_whitening)
		inValid |-> phase == load);

	creditBound: assert property (@(posedge CLK_Whitening) disable iff (!GO_whitening)
		credits <= CredBits'(OutCredits));

endmodule

//--- logic/whiteningMultiplier.sv
`timescale 1ns/1ns

module whiteningMultiplier (
	input  logic                   CLK_Whitening,
	input  logic                   GO_whitening,
	input  logic                   matLoad,
	input  whiteningPkg::matrixT   matIn,
	input  logic                   applyEn,
	input  whiteningPkg::centeredT centered,
	output whiteningPkg::sampleT   outSample
);

	import whiteningPkg::*;

	localparam logic signed [34:0] RoundBias = 35'sd1 <<< (MatFrac - 1);

	matrixT             mat;
	logic signed [32:0] prod00;
	logic signed [32:0] prod01;
	logic signed [32:0] prod10;
	logic signed [32:0] prod11;
	logic signed [34:0] dot0;
	logic signed [34:0] dot1;
	logic signed [15:0] sat0;
	logic signed [15:0] sat1;

	function automatic logic signed [15:0] saturate(input logic signed [34:0] value);
		if (value > 35'sd32767) return 16'sh7fff;
		if (value < -35'sd32768) return 16'sh8000;
		return value[15:0];
	endfunction

	always_comb begin
		dot0 = prod00 + prod01 + RoundBias;
		dot1 = prod10 + prod11 + RoundBias;
		sat0 = saturate(dot0 >>> MatFrac); // round half up, then clip
		sat1 = saturate(dot1 >>> MatFrac);
	end

	// stage one
	always_ff @(posedge CLK_Whitening) begin
		if (matLoad) mat <= matIn;
		if (applyEn) begin
			prod00 <= mat.w00 * centered.ch0;
			prod01 <= mat.w01 * centered.ch1;
			prod10 <= mat.w10 * centered.ch0;
			prod11 <= mat.w11 * centered.ch1;
		end
	end

	// stage two
	always_ff @(posedge CLK_Whitening or negedge GO_whitening) begin
		if (!GO_whitening) begin
			outSample <= '0;
		end else if (applyEn) begin
			outSample.ch0 <= sat0;
			outSample.ch1 <= sat1;
		end
	end

endmodule

//--- logic/whiteningPkg.sv
package whiteningPkg;

	localparam int MatFrac = 14; // fraction bits of the Q2.14 matrix

	typedef struct packed {
		logic signed [15:0] ch0;
		logic signed [15:0] ch1;
	} sampleT;

	// raw sample minus block mean, one bit wider
	typedef struct packed {
		logic signed [16:0] ch0;
		logic signed [16:0] ch1;
	} centeredT;

	typedef struct packed {
		logic signed [47:0] c00;
		logic signed [47:0] c01;
		logic signed [47:0] c11;
	} covT;

	typedef struct packed {
		logic signed [15:0] w00;
		logic signed [15:0] w01;
		logic signed [15:0] w10;
		logic signed [15:0] w11;
	} matrixT;

	typedef enum logic [2:0] {
		idle,
		load,
		mean,
		cov,
		drain,
		await,
		apply,
		finish
	} phaseT;

endpackage

//--- logic/whiteningTop.sv
`timescale 1ns/1ns

module whiteningTop #(
	parameter int AddrBits = 7,
	parameter int OutCredits = 4
) (
	input  logic                 CLK_Whitening,
	input  logic                 GO_whitening,
	input  logic                 start,
	output logic                 busy,
	output logic                 done,
	input  logic                 inValid,
	input  whiteningPkg::sampleT inSample,
	output logic                 inCredit,
	output logic                 covValid,
	output whiteningPkg::covT    covOut,
	input  logic                 matValid,
	input  whiteningPkg::matrixT matIn,
	output logic                 outValid,
	output whiteningPkg::sampleT outSample,
	input  logic                 outCredit
);

	import whiteningPkg::*;

	logic                wrEn;
	logic                rdEn;
	logic [AddrBits-1:0] addr;
	logic                accEn;
	logic                meanLoad;
	logic                covClear;
	logic                covEn;
	logic                covDone;
	logic                matLoad;
	logic                applyEn;
	sampleT              rdData;
	centeredT            centered; // shared by both passes

	whiteningController #(
		.AddrBits(AddrBits),
		.OutCredits(OutCredits)
	) ctrl0 (
		.CLK_Whitening(CLK_Whitening),
		.GO_whitening(GO_whitening),
		.start(start),
		.inValid(inValid),
		.matValid(matValid),
		.outCredit(outCredit),
		.busy(busy),
		.done(done),
		.inCredit(inCredit),
		.wrEn(wrEn),
		.rdEn(rdEn),
		.addr(addr),
		.accEn(accEn),
		.meanLoad(meanLoad),
		.covClear(covClear),
		.covEn(covEn),
		.covDone(covDone),
		.matLoad(matLoad),
		.applyEn(applyEn),
		.outValid(outValid)
	);

	sampleMemory #(.AddrBits(AddrBits)) mem0 (
		.CLK_Whitening(CLK_Whitening),
		.wrEn(wrEn),
		.rdEn(rdEn),
		.addr(addr),
		.wrData(inSample),
		.rdData(rdData)
	);

	centeringUnit #(.AddrBits(AddrBits)) cen0 (
		.CLK_Whitening(CLK_Whitening),
		.GO_whitening(GO_whitening),
		.accEn(accEn),
		.meanLoad(meanLoad),
		.start(start),
		.inSample(inSample),
		.rdData(rdData),
		.centered(centered)
	);

	covarianceAccumulator #(.AddrBits(AddrBits)) cov0 (
		.CLK_Whitening(CLK_Whitening),
		.GO_whitening(GO_whitening),
		.covClear(covClear),
		.covEn(covEn),
		.centered(centered),
		.covDone(covDone),
		.covValid(covValid),
		.covOut(covOut)
	);

	whiteningMultiplier mul0 (
		.CLK_Whitening(CLK_Whitening),
		.GO_whitening(GO_whitening),
		.matLoad(matLoad),
		.matIn(matIn),
		.applyEn(applyEn),
		.centered(centered),
		.outSample(outSample)
	);

endmodule

//--- whiteningTop.f
logic/whiteningPkg.sv
logic/whiteningController.sv
logic/sampleMemory.sv
logic/centeringUnit.sv
logic/covarianceAccumulator.sv
logic/whiteningMultiplier.sv
logic/whiteningTop.sv
dv/clockGen.sv
dv/whiteningChecker.sv
dv/whiteningTb.sv
